// ==== design/rvConfig_config.svh ====
// Core configuration macros
`ifndef RV_CONFIG_CONFIG_SVH
`define RV_CONFIG_CONFIG_SVH

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Architectural integer registers, x0 included
`define RV_REG_COUNT 32

`endif

// ==== design/rvPkg.sv ====
// RV32I shared types
`default_nettype none

package rvPkg;

    // ALU operation select
    // PASSB forwards operand B untouched for LUI
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASSB
    } aluOp_t;

    // Register write-back source
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PCPLUS4} wbSel_t;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // Register-register format
    typedef struct packed {
        logic [6:0] func7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_t;

    // Immediate and load format
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  func3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType_t;

    // Store format, immediate split around rs fields
    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sType_t;

    // Branch format
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bType_t;

    // Upper immediate format
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uType_t;

    // Jump format
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jType_t;

    // One instruction word, six views
    typedef union packed {
        rType_t r;
        iType_t i;
        sType_t s;
        bType_t b;
        uType_t u;
        jType_t j;
    } instrWord_t;

endpackage

`default_nettype wire

// ==== design/rvDecode.sv ====
// RV32I decode stage
`default_nettype none

module rvDecode (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          instrLoad,
    input  wire logic [31:0]   instrData,
    output logic [4:0]         rs1,
    output logic [4:0]         rs2,
    output logic [4:0]         rd,
    output logic [31:0]        imm,
    output logic [2:0]         func3,
    output rvPkg::aluOp_t      aluOp,
    output logic               aluSrcImm,
    output logic               aluSrcPc,
    output logic               regWrite,
    output logic               memRead,
    output logic               memWrite,
    output logic               branch,
    output logic               jump,
    output logic               jumpReg,
    output rvPkg::wbSel_t      wbSel
);
    import rvPkg::*;

    // Instruction register
    instrWord_t ir;

    // Sign-extended immediates per format
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;

    // func3 to ALU op for OP and OP-IMM
    // SUB only exists in the register form
    function automatic aluOp_t funcOp(
        input logic [2:0] f3,
        input logic       alt,
        input logic       regOp
    );
        aluOp_t op;
        case (f3)
            3'b000:  op = (alt && regOp) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // Zero word is an unknown opcode, so reset leaves a NOP
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ir <= '0;
        end
        else if (instrLoad)
        begin
            ir <= instrData;
        end
    end

    // Register fields sit at the same bits in every format
    assign rs1   = ir.r.rs1;
    assign rs2   = ir.r.rs2;
    assign rd    = ir.r.rd;
    assign func3 = ir.r.func3;

    assign immI = {{20{ir.i.imm[11]}}, ir.i.imm};
    assign immS = {{20{ir.s.immHi[6]}}, ir.s.immHi, ir.s.immLo};
    // Branch offsets are in halfwords
    assign immB = {{19{ir.b.imm12}}, ir.b.imm12, ir.b.imm11, ir.b.imm10to5,
                   ir.b.imm4to1, 1'b0};
    assign immU = {ir.u.imm, 12'b0};
    assign immJ = {{11{ir.j.imm20}}, ir.j.imm20, ir.j.imm19to12, ir.j.imm11,
                   ir.j.imm10to1, 1'b0};

    always_comb
    begin
        // NOP defaults
        imm       = '0;
        aluOp     = ALU_ADD;
        aluSrcImm = 1'b0;
        aluSrcPc  = 1'b0;
        regWrite  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        jumpReg   = 1'b0;
        wbSel     = WB_ALU;
        case (ir.r.opcode)
            OPC_LUI:
            begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = ALU_PASSB;
                imm       = immU;
            end
            OPC_AUIPC:
            begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluSrcPc  = 1'b1;
                imm       = immU;
            end
            // ALU forms PC + imm as the target, link comes from PC + 4
            OPC_JAL:
            begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                aluSrcImm = 1'b1;
                aluSrcPc  = 1'b1;
                wbSel     = WB_PCPLUS4;
                imm       = immJ;
            end
            // Target is rs1 + imm
            OPC_JALR:
            begin
                regWrite  = 1'b1;
                jumpReg   = 1'b1;
                aluSrcImm = 1'b1;
                wbSel     = WB_PCPLUS4;
                imm       = immI;
            end
            // Compare runs on rs1/rs2 beside the target add
            OPC_BRANCH:
            begin
                branch    = 1'b1;
                aluSrcImm = 1'b1;
                aluSrcPc  = 1'b1;
                imm       = immB;
            end
            // Word access only, func3 not checked
            OPC_LOAD:
            begin
                regWrite  = 1'b1;
                memRead   = 1'b1;
                aluSrcImm = 1'b1;
                wbSel     = WB_MEM;
                imm       = immI;
            end
            OPC_STORE:
            begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
                imm       = immS;
            end
            OPC_OPIMM:
            begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = funcOp(ir.r.func3, ir.r.func7[5], 1'b0);
                imm       = immI;
            end
            OPC_OP:
            begin
                regWrite = 1'b1;
                aluOp    = funcOp(ir.r.func3, ir.r.func7[5], 1'b1);
            end
            // FENCE, SYSTEM and unknown words keep the NOP defaults
            default:
            begin
                regWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/rvRegFile.sv ====
// Integer register file
`default_nettype none

`include "rvConfig_config.svh"

module rvRegFile (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [4:0]  rs1,
    input  wire logic [4:0]  rs2,
    input  wire logic        wrEn,
    input  wire logic [4:0]  wrAddr,
    input  wire logic [31:0] wrData,
    output logic [31:0]      rs1Data,
    output logic [31:0]      rs2Data
);

    logic [31:0] regs [`RV_REG_COUNT];

    // All entries cleared on reset
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < `RV_REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        // x0 writes dropped
        else if (wrEn && (wrAddr != 5'd0))
        begin
            regs[wrAddr] <= wrData;
        end
    end

    // Asynchronous reads, x0 forced to zero
    assign rs1Data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

// ==== design/rvAlu.sv ====
// Integer ALU and branch compare
`default_nettype none

module rvAlu (
    input  wire rvPkg::aluOp_t op,
    input  wire logic [31:0]   a,
    input  wire logic [31:0]   b,
    input  wire logic [2:0]    func3,
    input  wire logic [31:0]   cmpA,
    input  wire logic [31:0]   cmpB,
    output logic [31:0]        result,
    output logic               taken
);
    import rvPkg::*;

    logic cmpEq;
    logic cmpLt;
    logic cmpLtu;

    always_comb
    begin
        case (op)
            ALU_ADD:   result = a + b;
            ALU_SUB:   result = a - b;
            // Shift amount from low five bits
            ALU_SLL:   result = a << b[4:0];
            ALU_SLT:   result = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU:  result = {31'd0, a < b};
            ALU_XOR:   result = a ^ b;
            ALU_SRL:   result = a >> b[4:0];
            ALU_SRA:   result = $unsigned($signed(a) >>> b[4:0]);
            ALU_OR:    result = a | b;
            ALU_AND:   result = a & b;
            ALU_PASSB: result = b;
            default:   result = a + b;
        endcase
    end

    // Branch compare, independent of the adder
    assign cmpEq  = (cmpA == cmpB);
    assign cmpLt  = ($signed(cmpA) < $signed(cmpB));
    assign cmpLtu = (cmpA < cmpB);

    always_comb
    begin
        case (func3)
            3'b000:  taken = cmpEq;
            3'b001:  taken = !cmpEq;
            3'b100:  taken = cmpLt;
            3'b101:  taken = !cmpLt;
            3'b110:  taken = cmpLtu;
            3'b111:  taken = !cmpLtu;
            // 010 and 011 are not branches
            default: taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/rvLoadStore.sv ====
// APB load/store requester
`default_nettype none

module rvLoadStore (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        start,
    input  wire logic        write,
    input  wire logic [31:0] addr,
    input  wire logic [31:0] storeData,
    input  wire logic [31:0] prdata,
    input  wire logic        pready,
    output logic             done,
    output logic [31:0]      loadData,
    output logic             psel,
    output logic             penable,
    output logic             pwrite,
    output logic [31:0]      paddr,
    output logic [31:0]      pwdata
);

    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} lsState_t;

    lsState_t    state;
    logic [31:0] loadReg;

    // APB phase sequence
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:    state <= start ? SETUP : IDLE;
                SETUP:   state <= ACCESS;
                // Held in access while slave stalls
                ACCESS:  state <= pready ? IDLE : ACCESS;
                default: state <= IDLE;
            endcase
        end
    end

    // Request fields latched once, stable until completion
    always_ff @(posedge clk)
    begin
        if (start && (state == IDLE))
        begin
            paddr  <= {addr[31:2], 2'b00};
            pwrite <= write;
            pwdata <= storeData;
        end
        if (done && !pwrite)
        begin
            loadReg <= prdata;
        end
    end

    assign psel    = (state != IDLE);
    assign penable = (state == ACCESS);
    assign done    = (state == ACCESS) && pready;

    // Read data passed through in the completing cycle
    assign loadData = done ? prdata : loadReg;

endmodule

`default_nettype wire

// ==== design/rvCore.sv ====
// RV32I multi-cycle core
`default_nettype none

`include "rvConfig_config.svh"

module rvCore (
    input  wire logic        clk,
    input  wire logic        rst,
    // Instruction fetch, single cycle
    output logic             instrReq,
    output logic [31:0]      instrAddr,
    input  wire logic [31:0] instrData,
    // APB data port
    output logic             psel,
    output logic             penable,
    output logic             pwrite,
    output logic [31:0]      paddr,
    output logic [31:0]      pwdata,
    input  wire logic [31:0] prdata,
    input  wire logic        pready
);
    import rvPkg::*;

    typedef enum logic [1:0] {FETCH, EXECUTE, MEMORY} coreState_t;

    coreState_t  state;
    logic [31:0] pc;
    logic [31:0] pcPlus4;
    logic [31:0] pcTarget;
    logic        redirect;
    logic        memAccess;
    logic        lsStart;
    logic        lsDone;
    logic [31:0] loadData;

    // Decode outputs
    logic [4:0]  rs1, rs2, rd;
    logic [31:0] imm;
    logic [2:0]  func3;
    aluOp_t      aluOp;
    wbSel_t      wbSel;
    logic        aluSrcImm, aluSrcPc, regWrite, memRead, memWrite;
    logic        branch, jump, jumpReg;

    // Datapath
    logic [31:0] rs1Data, rs2Data;
    logic [31:0] aluA, aluB, aluResult;
    logic        taken;
    logic        wrEn;
    logic [31:0] wrData;

    rvDecode decode_i (
        .clk(clk), .rst(rst), .instrLoad(instrReq), .instrData(instrData),
        .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .func3(func3), .aluOp(aluOp),
        .aluSrcImm(aluSrcImm), .aluSrcPc(aluSrcPc), .regWrite(regWrite),
        .memRead(memRead), .memWrite(memWrite), .branch(branch), .jump(jump),
        .jumpReg(jumpReg), .wbSel(wbSel)
    );

    rvRegFile regFile_i (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .wrEn(wrEn), .wrAddr(rd),
        .wrData(wrData), .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    rvAlu alu_i (
        .op(aluOp), .a(aluA), .b(aluB), .func3(func3), .cmpA(rs1Data),
        .cmpB(rs2Data), .result(aluResult), .taken(taken)
    );

    // Address is the ALU sum, store data straight from rs2
    rvLoadStore loadStore_i (
        .clk(clk), .rst(rst), .start(lsStart), .write(memWrite), .addr(aluResult),
        .storeData(rs2Data), .prdata(prdata), .pready(pready), .done(lsDone),
        .loadData(loadData), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata)
    );

    // FETCH -> EXECUTE -> FETCH, or through MEMORY for LW/SW
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= FETCH;
            pc    <= `RV_RESET_PC;
        end
        else
        begin
            case (state)
                FETCH:
                    state <= EXECUTE;
                EXECUTE:
                begin
                    state <= memAccess ? MEMORY : FETCH;
                    if (!memAccess)
                        pc <= redirect ? pcTarget : pcPlus4;
                end
                // Leave only when the APB transfer completes
                MEMORY:
                begin
                    if (lsDone)
                    begin
                        state <= FETCH;
                        pc    <= pcPlus4;
                    end
                end
                default:
                    state <= FETCH;
            endcase
        end
    end

    assign instrReq  = (state == FETCH);
    assign instrAddr = pc;

    // Operand muxes
    assign aluA = aluSrcPc ? pc : rs1Data;
    assign aluB = aluSrcImm ? imm : rs2Data;

    // Next PC, targets word aligned
    assign pcPlus4  = pc + 32'd4;
    assign redirect = jump || jumpReg || (branch && taken);
    assign pcTarget = {aluResult[31:2], 2'b00};

    assign memAccess = memRead || memWrite;
    assign lsStart   = (state == EXECUTE) && memAccess;

    // Loads write back in the completing APB cycle
    assign wrEn = regWrite && (((state == EXECUTE) && !memRead) ||
                               ((state == MEMORY) && lsDone));

    always_comb
    begin
        case (wbSel)
            WB_MEM:     wrData = loadData;
            WB_PCPLUS4: wrData = pcPlus4;
            default:    wrData = aluResult;
        endcase
    end

endmodule

`default_nettype wire

// ==== tb/rvCore_assertions.sv ====
// APB and fetch port assertions
`default_nettype none

module rvCoreAssertions (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic        instrReq,
    input wire logic        psel,
    input wire logic        penable,
    input wire logic        pwrite,
    input wire logic [31:0] paddr,
    input wire logic [31:0] pwdata,
    input wire logic        pready
);

    // Enable only inside a selected transfer
    enableWithSel: assert property (@(posedge clk) disable iff (rst)
        penable |-> psel)
        else $error("penable high without psel");

    // Request fields held until the completing cycle
    requestStable: assert property (@(posedge clk) disable iff (rst)
        (psel && !(penable && pready)) |=>
        (psel && $stable(paddr) && $stable(pwrite) && $stable(pwdata)))
        else $error("APB request dropped or changed before completion");

    // Fetch and data port never share a cycle
    fetchApart: assert property (@(posedge clk) disable iff (rst)
        !(psel && instrReq))
        else $error("psel high in a fetch cycle");

endmodule

bind rvCore rvCoreAssertions assertions_i (
    .clk(clk),
    .rst(rst),
    .instrReq(instrReq),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .pready(pready)
);

`default_nettype wire

// ==== tb/rvCoreTb.sv ====
// RV32I core testbench
`default_nettype none

`include "rvConfig_config.svh"

module rvCoreTb;
    import rvPkg::*;

    localparam int NumInstr    = 600;
    localparam int ResetCycles = 4;
    // At most 7 cycles per instruction, 8 budgeted
    localparam int TimeoutTime = NumInstr * 8 * 4 + ResetCycles * 4;

    logic        clk;
    logic        rst;
    logic        instrReq;
    logic [31:0] instrAddr;
    logic [31:0] instrData;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;

    // Reference model state
    logic [31:0] modelRegs [`RV_REG_COUNT];
    logic [31:0] modelPc;
    logic [31:0] lfsr = 32'hd9795f76;

    int valueErrors;
    int otherErrors;
    int instrIndex;
    int memCount;
    int cycle;
    int doneCount;

    rvCore dut_i (
        .clk(clk), .rst(rst), .instrReq(instrReq), .instrAddr(instrAddr),
        .instrData(instrData), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps 32, 22, 2, 1, one step per bit
    function automatic logic [31:0] randBits(input int count);
        logic [31:0] val;
        logic        fb;
        int          k;
        val = '0;
        for (k = 0; k < count; k++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // ISA result for OP and OP-IMM
    function automatic logic [31:0] aluModel(
        input logic [2:0]  f3,
        input logic        alt,
        input logic [31:0] a,
        input logic [31:0] b
    );
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b011:  return {31'd0, a < b};
            3'b100:  return a ^ b;
            3'b101:
            begin
                // SRA fills with the sign bit
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Branch condition by func3
    function automatic logic branchModel(
        input logic [2:0]  f3,
        input logic [31:0] a,
        input logic [31:0] b
    );
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic reportMismatch(
        input string       name,
        input logic [31:0] got,
        input logic [31:0] exp
    );
        valueErrors++;
        $display("CHECK FAILED %s: got 0x%08h expected 0x%08h at instruction %0d",
                 name, got, exp, instrIndex);
    endtask

    task automatic printSummary();
        $display("Summary: %0d instructions, %0d value errors, %0d other errors",
                 instrIndex, valueErrors, otherErrors);
    endtask

    // Cycle count and APB completions, pre-edge values
    always @(posedge clk)
    begin
        if (rst)
        begin
            cycle     <= 0;
            doneCount <= 0;
        end
        else
        begin
            cycle <= cycle + 1;
            if (psel && penable && pready)
                doneCount <= doneCount + 1;
        end
    end

    // Watchdog
    initial
    begin
        #(TimeoutTime);
        otherErrors++;
        $display("ERROR: run did not finish within %0d time units", TimeoutTime);
        printSummary();
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        instrWord_t  w;
        logic [31:0] r;
        logic [3:0]  cls;
        logic [4:0]  rdI;
        logic [4:0]  rs1I;
        logic [4:0]  rs2I;
        logic [2:0]  f3;
        logic [11:0] immField;
        logic [19:0] imm20;
        logic        alt;
        logic        wr;
        logic        isMem;
        logic        isStore;
        logic        aborted;
        logic [31:0] res;
        logic [31:0] nextPc;
        logic [31:0] memAddr;
        logic [31:0] memData;
        logic [31:0] loadVal;
        int          k;
        int          waits;
        int          waitCycles;
        int          lastFetch;
        int          expSpacing;
        int          startDone;

        valueErrors = 0;
        otherErrors = 0;
        memCount    = 0;
        instrIndex  = 0;
        rst         = 1'b1;
        instrData   = '0;
        prdata      = '0;
        pready      = 1'b0;
        aborted     = 1'b0;
        lastFetch   = 0;
        expSpacing  = 0;
        for (k = 0; k < `RV_REG_COUNT; k++)
            modelRegs[k] = '0;
        modelPc = `RV_RESET_PC;

        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (instrIndex = 0; instrIndex < NumInstr; instrIndex++)
        begin
            // Fetch request is due now
            waitCycles = 0;
            while (!instrReq && waitCycles < 8)
            begin
                @(negedge clk);
                waitCycles++;
            end
            if (!instrReq)
            begin
                otherErrors++;
                $display("ERROR: no fetch request for instruction %0d", instrIndex);
                break;
            end
            if (instrIndex == 0 && instrAddr != `RV_RESET_PC)
                reportMismatch("instrAddr", instrAddr, `RV_RESET_PC);
            if (instrAddr != modelPc)
                reportMismatch("instrAddr", instrAddr, modelPc);
            if (instrIndex > 0 && cycle - lastFetch != expSpacing)
            begin
                otherErrors++;
                $display("ERROR: instruction %0d fetched %0d cycles after the last, not %0d",
                         instrIndex, cycle - lastFetch, expSpacing);
            end
            lastFetch = cycle;

            // Random class and fields
            r = randBits(4);
            cls = r[3:0];
            r = randBits(5);
            rdI = r[4:0];
            r = randBits(5);
            rs1I = r[4:0];
            r = randBits(5);
            rs2I = r[4:0];
            r = randBits(3);
            f3 = r[2:0];
            r = randBits(12);
            immField = r[11:0];
            r = randBits(20);
            imm20 = r[19:0];
            r = randBits(1);
            alt = r[0];

            w       = '0;
            wr      = 1'b0;
            isMem   = 1'b0;
            isStore = 1'b0;
            res     = '0;
            memAddr = '0;
            memData = '0;
            nextPc  = modelPc + 32'd4;
            case (cls)
                4'd0, 4'd1, 4'd2, 4'd3:
                begin
                    // Shift immediates carry the amount in the low five bits
                    if (f3 == 3'b001)
                        immField[11:5] = 7'd0;
                    if (f3 == 3'b101)
                        immField[11:5] = {1'b0, alt, 5'd0};
                    w.i.opcode = OPC_OPIMM;
                    w.i.rd     = rdI;
                    w.i.func3  = f3;
                    w.i.rs1    = rs1I;
                    w.i.imm    = immField;
                    wr  = 1'b1;
                    res = aluModel(f3, alt && (f3 == 3'b101), modelRegs[rs1I],
                                   sext12(immField));
                end
                4'd4, 4'd5, 4'd6:
                begin
                    // Alternate form only for SUB and SRA
                    if (f3 != 3'b000 && f3 != 3'b101)
                        alt = 1'b0;
                    w.r.opcode = OPC_OP;
                    w.r.rd     = rdI;
                    w.r.func3  = f3;
                    w.r.rs1    = rs1I;
                    w.r.rs2    = rs2I;
                    w.r.func7  = {1'b0, alt, 5'd0};
                    wr  = 1'b1;
                    res = aluModel(f3, alt, modelRegs[rs1I], modelRegs[rs2I]);
                end
                4'd7, 4'd8:
                begin
                    w.u.opcode = (cls == 4'd7) ? OPC_LUI : OPC_AUIPC;
                    w.u.rd     = rdI;
                    w.u.imm    = imm20;
                    wr  = 1'b1;
                    res = {imm20, 12'd0};
                    if (cls == 4'd8)
                        res = modelPc + res;
                end
                4'd9:
                begin
                    // imm20 holds offset bits 20..1
                    w.j.opcode    = OPC_JAL;
                    w.j.rd        = rdI;
                    w.j.imm20     = imm20[19];
                    w.j.imm19to12 = imm20[18:11];
                    w.j.imm11     = imm20[10];
                    w.j.imm10to1  = imm20[9:0];
                    wr     = 1'b1;
                    res    = modelPc + 32'd4;
                    nextPc = (modelPc + {{11{imm20[19]}}, imm20, 1'b0}) & ~32'h3;
                end
                4'd10:
                begin
                    w.i.opcode = OPC_JALR;
                    w.i.rd     = rdI;
                    w.i.rs1    = rs1I;
                    w.i.imm    = immField;
                    wr     = 1'b1;
                    res    = modelPc + 32'd4;
                    nextPc = (modelRegs[rs1I] + sext12(immField)) & ~32'h3;
                end
                4'd11:
                begin
                    // 010 and 011 folded onto BEQ and BNE
                    if (f3[2:1] == 2'b01)
                        f3[1] = 1'b0;
                    // Equal operands half the time
                    if (alt)
                        rs2I = rs1I;
                    w.b.opcode   = OPC_BRANCH;
                    w.b.func3    = f3;
                    w.b.rs1      = rs1I;
                    w.b.rs2      = rs2I;
                    w.b.imm12    = immField[11];
                    w.b.imm11    = immField[10];
                    w.b.imm10to5 = immField[9:4];
                    w.b.imm4to1  = immField[3:0];
                    if (branchModel(f3, modelRegs[rs1I], modelRegs[rs2I]))
                        nextPc = (modelPc + {{19{immField[11]}}, immField, 1'b0}) & ~32'h3;
                end
                4'd12:
                begin
                    w.i.opcode = OPC_LOAD;
                    w.i.rd     = rdI;
                    w.i.func3  = 3'b010;
                    w.i.rs1    = rs1I;
                    w.i.imm    = immField;
                    wr      = 1'b1;
                    isMem   = 1'b1;
                    memAddr = (modelRegs[rs1I] + sext12(immField)) & ~32'h3;
                end
                4'd13, 4'd14:
                begin
                    w.s.opcode = OPC_STORE;
                    w.s.func3  = 3'b010;
                    w.s.rs1    = rs1I;
                    w.s.rs2    = rs2I;
                    w.s.immHi  = immField[11:5];
                    w.s.immLo  = immField[4:0];
                    isMem   = 1'b1;
                    isStore = 1'b1;
                    memAddr = (modelRegs[rs1I] + sext12(immField)) & ~32'h3;
                    memData = modelRegs[rs2I];
                end
                default:
                begin
                    // FENCE, ECALL and two unknown opcodes
                    r = randBits(25);
                    case (f3[1:0])
                        2'd0:    w = 32'h0ff0_000f;
                        2'd1:    w = 32'h0000_0073;
                        2'd2:    w = {r[24:0], 7'b0000000};
                        default: w = {r[24:0], 7'b1111111};
                    endcase
                end
            endcase

            instrData = w;
            @(negedge clk);
            // Execute cycle
            if (psel)
            begin
                otherErrors++;
                $display("ERROR: APB select raised in execute of instruction %0d", instrIndex);
            end
            if (isMem)
            begin
                startDone = doneCount;
                @(negedge clk);
                if (!psel || penable)
                begin
                    otherErrors++;
                    $display("ERROR: no APB setup phase for instruction %0d", instrIndex);
                end
                if (paddr != memAddr)
                    reportMismatch("paddr", paddr, memAddr);
                if (pwrite != isStore)
                    reportMismatch("pwrite", {31'd0, pwrite}, {31'd0, isStore});
                if (isStore && pwdata != memData)
                    reportMismatch("pwdata", pwdata, memData);
                r = randBits(2);
                waits   = r;
                loadVal = randBits(32);
                prdata  = loadVal;
                // pready rises in the last of waits + 1 access cycles
                for (k = 0; k <= waits; k++)
                begin
                    @(negedge clk);
                    if (!(psel && penable))
                    begin
                        otherErrors++;
                        $display("ERROR: APB access phase lost at instruction %0d",
                                 instrIndex);
                        aborted = 1'b1;
                        break;
                    end
                    pready = (k == waits);
                end
                if (aborted)
                    break;
                @(negedge clk);
                pready = 1'b0;
                if (doneCount != startDone + 1)
                begin
                    otherErrors++;
                    $display("ERROR: APB access of instruction %0d completed %0d times",
                             instrIndex, doneCount - startDone);
                end
                memCount++;
                if (!isStore)
                    res = loadVal;
                expSpacing = 4 + waits;
            end
            else
            begin
                @(negedge clk);
                expSpacing = 2;
            end

            // Retire in the model, x0 stays zero
            if (wr && rdI != 5'd0)
                modelRegs[rdI] = res;
            modelPc = nextPc;
        end

        if (doneCount != memCount)
        begin
            otherErrors++;
            $display("ERROR: %0d APB completions for %0d memory instructions",
                     doneCount, memCount);
        end
        printSummary();
        if (valueErrors == 0 && otherErrors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+design
design/rvPkg.sv
design/rvDecode.sv
design/rvRegFile.sv
design/rvAlu.sv
design/rvLoadStore.sv
design/rvCore.sv
tb/rvCore_assertions.sv
tb/rvCoreTb.sv

// ==== Makefile ====
# Verilator flow for the RV32I core testbench
SIM = obj_dir/VrvCoreTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module rvCoreTb -f build.f

# Pass only if the log holds the pass line
run: compile
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
